// ==== all.f ====
+incdir+bench
logic/cart_pkg.sv
logic/cart_config.sv
logic/bsx_reg_file.sv
logic/cart_addr_map.sv
logic/enable_filter.sv
logic/cart_addr_top.sv
bench/tb_cart_addr.sv

// ==== bench/cart_ref_model.svh ====
`ifndef CART_REF_MODEL_SVH
`define CART_REF_MODEL_SVH

////////////////////////////////////////
// Model state, follows testbench writes
////////////////////////////////////////

cart_pkg::mapper_t ref_mapper    = cart_pkg::menu;
logic [23:0]       ref_rom_mask  = '1;
logic [23:0]       ref_sram_mask = '1;
logic [14:0]       ref_regs      = '0;   // BS-X bits, 0 spare

function automatic void note_cfg_write(input cart_pkg::cfg_sel_t sel, input logic [23:0] data);
   case (sel)
      cart_pkg::cfg_mapper:       ref_mapper    = cart_pkg::mapper_t'(data[2:0]);
      cart_pkg::cfg_rom_mask:     ref_rom_mask  = data;
      cart_pkg::cfg_saveram_mask: ref_sram_mask = data;
      default: ;
   endcase
endfunction

// Register window 01-0E:5000, D7 only
function automatic void note_bus_write(input logic [23:0] addr, input logic [7:0] data);
   if (ref_mapper == cart_pkg::bsx && addr[23:16] >= 8'h01 && addr[23:16] <= 8'h0E
       && addr[15:0] == 16'h5000) begin
      ref_regs[addr[19:16]] = data[7];
   end
endfunction

////////////////////////////////////////
// Expected decode of a console address
////////////////////////////////////////

function automatic cart_pkg::map_out_t expect_map(input logic [23:0] addr);
   cart_pkg::map_out_t m;
   logic [7:0]  bank;
   logic [6:0]  b7;        // Bank without the 80 mirror bit
   logic [15:0] off;
   logic        hi_ram, lo_ram, bs_ram, bs_ps, bs_cart, rom;
   bank = addr[23:16];
   b7   = bank[6:0];
   off  = addr[15:0];
   m        = '0;
   m.dsp_a0 = 1'b1;
   rom     = bank[6] || off[15];
   hi_ram  = b7 >= 7'h30 && b7 <= 7'h3F && off >= 16'h6000 && off <= 16'h7FFF;
   lo_ram  = b7 >= 7'h70 && b7 <= 7'h7D && off <= 16'h7FFF;
   bs_ram  = bank >= 8'h10 && bank <= 8'h17 && off[15:12] == 4'h5;
   bs_ps   = (ref_regs[3] && bank[7:4] == 4'h6) || (!ref_regs[5] && bank[7:4] == 4'h4)
          || (!ref_regs[6] && bank[7:4] == 4'h5) || (bank >= 8'h70 && bank <= 8'h77)
          || (bank >= 8'h20 && bank <= 8'h3F && off >= 16'h6000 && off <= 16'h7FFF);
   bs_cart = (ref_regs[7] && bank <= 8'h1F) || (ref_regs[8] && bank >= 8'h80 && bank <= 8'h9F);
   m.msu_en  = !bank[6] && off >= 16'h2000 && off <= 16'h2007;
   m.srtc_en = !bank[6] && (off == 16'h2800 || off == 16'h2801);
   case (ref_mapper)
      cart_pkg::hirom, cart_pkg::dsp_hi, cart_pkg::exhirom, cart_pkg::menu: begin
         m.is_rom      = rom;
         m.is_saveram  = hi_ram;
         m.is_writable = hi_ram;
         if (hi_ram) begin
            m.mem_addr = ({8'h00, off - 16'h6000} & ref_sram_mask)
                       + (ref_mapper == cart_pkg::menu ? cart_pkg::menu_saveram_base
                                                       : cart_pkg::saveram_base);
         end else if (ref_mapper == cart_pkg::exhirom) begin
            m.mem_addr = {1'b0, ~bank[7], addr[21:0]} & ref_rom_mask;   // Bank 80+ first
         end else if (ref_mapper == cart_pkg::menu) begin
            m.mem_addr = ({1'b0, addr[22:0]} & ref_rom_mask) + cart_pkg::menu_rom_base;
         end else begin
            m.mem_addr = {1'b0, addr[22:0]} & ref_rom_mask;
         end
      end
      cart_pkg::lorom, cart_pkg::dsp_lo: begin
         m.is_rom      = rom;
         m.is_saveram  = lo_ram;
         m.is_writable = lo_ram;
         m.mem_addr    = lo_ram ? cart_pkg::saveram_base + ({9'd0, off[14:0]} & ref_sram_mask)
                                : {2'b00, b7, off[14:0]} & ref_rom_mask;   // 32K per bank
      end
      cart_pkg::bsx: begin
         m.is_rom      = rom;
         m.is_saveram  = bs_ram;
         m.is_writable = bs_ram || bs_ps;
         if (bs_ram)
            m.mem_addr = cart_pkg::saveram_base + {9'd0, bank[2:0], off[11:0]};
         else if (bs_ps)
            m.mem_addr = cart_pkg::bsx_psram_base + {4'h0, addr[19:0]};
         else if (bs_cart)
            m.mem_addr = cart_pkg::bsx_cart_base + {4'h0, bank[4:0], off[14:0]};
         else
            m.mem_addr = (ref_regs[1] ? cart_pkg::bsx_psram_base : 24'd0)
                       + (ref_regs[2] ? {2'b00, addr[21:0]} & ref_rom_mask
                                      : {1'b0, bank, off[14:0]} & ref_rom_mask);
      end
      default: ;   // Special, nothing mapped
   endcase
   if (ref_mapper == cart_pkg::dsp_lo) begin
      m.dsp_hit = ref_rom_mask[20] ? (b7[6:4] == 3'h6 && !off[15]) : (b7[6:4] == 3'h3 && off[15]);
      m.dsp_a0  = off[14];
   end else if (ref_mapper == cart_pkg::dsp_hi) begin
      m.dsp_hit = b7[6:4] == 3'h0 && off >= 16'h6000 && off <= 16'h7FFF;
      m.dsp_a0  = off[12];
   end
   return m;
endfunction

`endif

// ==== bench/tb_cart_addr.sv ====
`timescale 1ns/1ps

module tb_cart_addr;

   localparam int FILTER_DEPTH = 4;
   localparam int HOLD         = FILTER_DEPTH + 2;   // Cycles per request
   localparam int CLK_PERIOD   = 100;
   localparam int MAP_REQS     = 12;                 // Per mapper
   localparam int PHASE_REQS   = 16;
   localparam int BSX_REQS     = 24;                 // Writes and then as many reads
   localparam int PORT_REQS    = 32;
   localparam int REQ_TOTAL    = 7 * MAP_REQS + PHASE_REQS + 2 * BSX_REQS + PORT_REQS + 8;
   localparam int WATCHDOG_CYCLES = REQ_TOTAL * HOLD + 400;

   logic                CLK;
   logic                rst_n;
   cart_pkg::snes_req_t req;
   logic [23:0]         mcu_addr;
   logic                mcu_phase;
   logic                cfg_write;
   cart_pkg::cfg_sel_t  cfg_sel;
   logic [23:0]         cfg_data;
   cart_pkg::map_out_t  map;
   logic                dsp_enable;
   logic                use_bsx;

   logic [31:0] lfsr   = 32'd51;   // Seed
   int          checks = 0;
   int          errors = 0;
   int          mark   = 0;        // Error count at start of test
   cart_pkg::mapper_t mapper_list [7] = '{cart_pkg::hirom, cart_pkg::lorom, cart_pkg::exhirom,
      cart_pkg::bsx, cart_pkg::dsp_hi, cart_pkg::dsp_lo, cart_pkg::menu};

   `include "cart_ref_model.svh"

   cart_addr_top #(
      .FILTER_DEPTH (FILTER_DEPTH)
   ) u_dut (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .req        (req),
      .mcu_addr   (mcu_addr),
      .mcu_phase  (mcu_phase),
      .cfg_write  (cfg_write),
      .cfg_sel    (cfg_sel),
      .cfg_data   (cfg_data),
      .map        (map),
      .dsp_enable (dsp_enable),
      .use_bsx    (use_bsx)
   );

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   task automatic check_value(input string test, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
      checks++;
      assert (actual === expected) else begin
         $display("mismatch %s %s expected %h actual %h", test, field, expected, actual);
         errors++;
      end
   endtask

   task automatic report_test(input string test);
      $display("test %s %0d errors", test, errors - mark);
      mark = errors;
   endtask

   // One cycle strobe and the register lands one edge later
   task automatic write_config(input cart_pkg::cfg_sel_t sel, input logic [23:0] data);
      @(posedge CLK);
      cfg_write <= 1'b1;
      cfg_sel   <= sel;
      cfg_data  <= data;
      @(posedge CLK);
      cfg_write <= 1'b0;
      note_cfg_write(sel, data);
   endtask

   // Request held HOLD cycles and ending on a settled falling edge
   task automatic drive_request(input logic [23:0] addr, input logic wr, input logic [7:0] data,
                                input logic [23:0] m_addr, input logic phase);
      @(posedge CLK);
      req.addr  <= addr;
      req.wr    <= wr;
      req.data  <= data;
      mcu_addr  <= m_addr;
      mcu_phase <= phase;
      if (wr) note_bus_write(addr, data);
      @(posedge CLK);
      req.wr <= 1'b0;   // Single write edge
      repeat (HOLD - 2) @(posedge CLK);
      @(negedge CLK);
   endtask

   ////////////////////////////////////////
   // Clock and watchdog
   ////////////////////////////////////////

   initial begin
      CLK = 1'b0;
      forever #(CLK_PERIOD / 2) CLK = ~CLK;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
      $display("Regression failed");
      $finish;
   end

   ////////////////////////////////////////
   // Tests
   ////////////////////////////////////////

   initial begin
      logic [23:0]        addr;
      logic [23:0]        maddr;
      logic [2:0]         code;
      logic [1:0]         pick;
      cart_pkg::map_out_t exp;
      rst_n     = 1'b0;
      req       = '0;
      mcu_addr  = '0;
      mcu_phase = 1'b0;
      cfg_write = 1'b0;
      cfg_sel   = cart_pkg::cfg_mapper;
      cfg_data  = '0;
      repeat (2) @(posedge CLK);
      rst_n <= 1'b1;
      @(negedge CLK);

      // Reset values with menu mapper and full masks
      check_value("reset", "map", 32'd0, map);
      check_value("reset", "dsp_enable", 32'd0, dsp_enable);
      check_value("reset", "use_bsx", 32'd0, use_bsx);
      addr = {1'b1, 1'b1, 22'(rand_bits(22))};   // ROM area
      drive_request(addr, 1'b0, 8'h00, 24'h0, 1'b0);
      exp = expect_map(addr);
      check_value("reset", "mem_addr", exp.mem_addr, map.mem_addr);
      report_test("reset");

      // Each decoded mapper with random masks
      for (int i = 0; i < 7; i++) begin
         code = mapper_list[i];
         write_config(cart_pkg::cfg_mapper, {21'(rand_bits(21)), code});   // Junk upper bits
         write_config(cart_pkg::cfg_rom_mask, 24'(rand_bits(24)));
         write_config(cart_pkg::cfg_saveram_mask, 24'(rand_bits(24)));
         repeat (MAP_REQS) begin
            addr = 24'(rand_bits(24));
            if (rand_bits(1)) begin
               addr[22:20] = rand_bits(1) ? 3'b011 : 3'b111;   // Save-RAM banks 3x or 7x
               addr[15:13] = 3'b011;                           // Offsets 6000-7FFF
            end
            drive_request(addr, 1'b0, 8'h00, 24'(rand_bits(24)), 1'b0);
            exp = expect_map(addr);
            check_value("mappers", "mem_addr", exp.mem_addr, map.mem_addr);
            check_value("mappers", "is_rom", exp.is_rom, map.is_rom);
            check_value("mappers", "is_saveram", exp.is_saveram, map.is_saveram);
            check_value("mappers", "is_writable", exp.is_writable, map.is_writable);
         end
      end
      report_test("mappers");

      // Microcontroller phase under any mapper
      repeat (PHASE_REQS) begin
         write_config(cart_pkg::cfg_mapper, 24'(rand_bits(3)));
         addr  = 24'(rand_bits(24));
         maddr = 24'(rand_bits(24));
         drive_request(addr, 1'b0, 8'h00, maddr, 1'b1);
         check_value("phase", "mem_addr", maddr, map.mem_addr);
      end
      report_test("phase");

      // BS-X register writes and then reads through them
      write_config(cart_pkg::cfg_mapper, 24'(cart_pkg::bsx));
      write_config(cart_pkg::cfg_rom_mask, 24'(rand_bits(24)));
      write_config(cart_pkg::cfg_saveram_mask, 24'(rand_bits(24)));
      repeat (BSX_REQS) begin
         addr = rand_bits(1) ? {4'h0, 4'(rand_bits(4)), 16'h5000} : 24'(rand_bits(24));
         drive_request(addr, 1'b1, 8'(rand_bits(8)), 24'h0, 1'b0);
      end
      check_value("bsx", "use_bsx", 32'd1, use_bsx);
      repeat (BSX_REQS) begin
         addr = 24'(rand_bits(24));
         drive_request(addr, 1'b0, 8'h00, 24'h0, 1'b0);
         exp = expect_map(addr);
         check_value("bsx", "is_writable", exp.is_writable, map.is_writable);
         check_value("bsx", "mem_addr", exp.mem_addr, map.mem_addr);
      end
      report_test("bsx");

      // Port flags and DSP selects with offsets steered at the windows
      for (int i = 0; i < PORT_REQS; i++) begin
         if (i % 8 == 0) begin
            write_config(cart_pkg::cfg_mapper,
                         rand_bits(1) ? 24'(cart_pkg::dsp_hi) : 24'(cart_pkg::dsp_lo));
            write_config(cart_pkg::cfg_rom_mask, 24'(rand_bits(24)));   // Bit 20 moves window
         end
         pick = 2'(rand_bits(2));
         case (pick)
            2'd0:    addr = {8'(rand_bits(8)), 12'h200, 4'(rand_bits(4))};    // MSU and above
            2'd1:    addr = {8'(rand_bits(8)), 14'h0A00, 2'(rand_bits(2))};   // RTC area
            2'd2:    addr = {8'(rand_bits(8)), 3'b011, 13'(rand_bits(13))};   // 6000-7FFF
            default: addr = 24'(rand_bits(24));
         endcase
         drive_request(addr, 1'b0, 8'h00, 24'h0, 1'b0);
         exp = expect_map(addr);
         check_value("ports_dsp", "msu_en", exp.msu_en, map.msu_en);
         check_value("ports_dsp", "srtc_en", exp.srtc_en, map.srtc_en);
         check_value("ports_dsp", "dsp_a0", exp.dsp_a0, map.dsp_a0);
         check_value("ports_dsp", "dsp_hit", exp.dsp_hit, map.dsp_hit);
         check_value("ports_dsp", "dsp_enable", exp.dsp_hit, dsp_enable);   // Settled after hold
      end
      report_test("ports_dsp");

      // Short hit on 00:6000 is filtered out
      write_config(cart_pkg::cfg_mapper, 24'(cart_pkg::dsp_hi));
      drive_request(24'h008000, 1'b0, 8'h00, 24'h0, 1'b0);
      check_value("dsp_glitch", "idle_enable", 32'd0, dsp_enable);
      @(posedge CLK);
      req.addr <= 24'h006000;
      repeat (FILTER_DEPTH - 1) @(posedge CLK);
      req.addr <= 24'h008000;
      repeat (2 * HOLD) begin
         @(negedge CLK);
         check_value("dsp_glitch", "short_enable", 32'd0, dsp_enable);
      end
      drive_request(24'h006000, 1'b0, 8'h00, 24'h0, 1'b0);
      check_value("dsp_glitch", "held_enable", 32'd1, dsp_enable);
      report_test("dsp_glitch");

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// ==== logic/bsx_reg_file.sv ====
`timescale 1ns/1ps

module bsx_reg_file (
   input  logic                 CLK,
   input  logic                 rst_n,
   input  cart_pkg::snes_req_t  req,
   input  cart_pkg::mapper_t    mapper,
   output logic [14:0]          bsx_regs   // Bit n holds register n
);

   // BS-X control window at offset 5000 of banks 01-0F
   localparam logic [15:0] reg_offset = 16'h5000;

   logic [3:0] reg_idx;     // Bank low nibble
   logic       in_window;
   logic       reg_wr;

   ////////////////////////////////////////
   // Window decode
   ////////////////////////////////////////

   assign reg_idx   = req.addr[19:16];
   assign in_window = (req.addr[23:20] == 4'h0) && (req.addr[15:0] == reg_offset);

   // Index 0 has no register
   // Bank 0F falls past the top register bit
   assign reg_wr = req.wr
                && (mapper == cart_pkg::bsx)
                && in_window
                && (reg_idx != 4'h0)
                && (reg_idx != 4'hF);

   ////////////////////////////////////////
   // Register bits
   ////////////////////////////////////////

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         bsx_regs <= '0;
      end else if (reg_wr) begin
         bsx_regs[reg_idx] <= req.data[7];   // Only D7 carries state
      end
   end

   // Any change traces back to a decoded write one edge earlier
   regs_change_on_write: assert property (
      @(posedge CLK) disable iff (!rst_n)
      !$stable(bsx_regs) |-> $past(reg_wr)
   );

endmodule

// ==== logic/cart_addr_map.sv ====
`timescale 1ns/1ps

module cart_addr_map (
   input  logic                 CLK,
   input  logic                 rst_n,
   input  cart_pkg::snes_req_t  req,
   input  logic [23:0]          mcu_addr,
   input  logic                 mcu_phase,   // 1 when microcontroller owns memory
   input  cart_pkg::map_cfg_t   cfg,
   input  logic [14:0]          bsx_regs,
   output cart_pkg::map_out_t   map
);

   logic [23:0]        a;            // Console address shorthand
   logic               rom_area;     // Bank bit 22 or upper half of bank
   logic               hi_sram;      // 30-3F:6000-7FFF
   logic               lo_sram;      // 70-7D, lower half
   logic               bsx_sram;     // 10-17:5000-5FFF
   logic               bsx_psram;    // PSRAM windows opened by BS-X regs
   logic               bsx_writable;
   logic               bsx_cart;     // BS-X cartridge ROM mapped in
   logic [23:0]        off_6000;     // Save-RAM offset from 6000
   logic [23:0]        lo_rom_addr;  // LoROM packing, bank 22:16
   logic [23:0]        bsx_lo_addr;  // BS-X packing, full bank
   logic [23:0]        bsx_rom_addr;
   cart_pkg::map_out_t map_d;

   ////////////////////////////////////////
   // Region terms
   ////////////////////////////////////////

   assign a        = req.addr;
   assign rom_area = a[22] | a[15];
   assign hi_sram  = !a[22] & (&a[21:20]) & (&a[14:13]) & !a[15];
   assign lo_sram  = (&a[22:20]) & (a[19:16] < 4'hE) & !a[15];
   assign bsx_sram = (a[23:19] == 5'b00010) & (a[15:12] == 4'h5);

   // Reg 3 mirrors PSRAM at 60-6F, regs 5 and 6 drop the 40 and 50 mirrors
   assign bsx_psram = (bsx_regs[3] && a[23:20] == 4'h6)
                   | (!bsx_regs[5] && a[23:20] == 4'h4)
                   | (!bsx_regs[6] && a[23:20] == 4'h5)
                   | (a[23:19] == 5'b01110)                        // 70-77
                   | (a[23:21] == 3'b001 && a[15:13] == 3'b011);   // 20-3F:6000
   assign bsx_writable = bsx_sram | bsx_psram;

   // Regs 7 and 8 map cartridge ROM at 00-1F and 80-9F
   assign bsx_cart = (bsx_regs[7] && a[23:21] == 3'b000)
                  | (bsx_regs[8] && a[23:21] == 3'b100);

   ////////////////////////////////////////
   // Address pieces
   ////////////////////////////////////////

   assign off_6000    = {9'd0, a[14:0] - 15'h6000};
   assign lo_rom_addr = {2'b00, a[22:16], a[14:0]};
   assign bsx_lo_addr = {1'b0, a[23:16], a[14:0]};

   // Reg 1 selects PSRAM over flash, reg 2 selects HiROM packing
   assign bsx_rom_addr = (bsx_regs[1] ? cart_pkg::bsx_psram_base : 24'd0)
                       + (bsx_regs[2] ? ({2'b00, a[21:0]} & cfg.rom_mask)
                                      : (bsx_lo_addr & cfg.rom_mask));

   ////////////////////////////////////////
   // Mapper decode
   ////////////////////////////////////////

   always_comb begin
      map_d        = '0;
      map_d.dsp_a0 = 1'b1;   // Idle level off the DSP mappers

      // Ports decode the same for every mapper
      map_d.msu_en  = !a[22] && ((a[15:0] & 16'hFFF8) == 16'h2000);
      map_d.srtc_en = !a[22] && ((a[15:0] & 16'hFFFE) == 16'h2800);

      case (cfg.mapper)
         cart_pkg::hirom, cart_pkg::dsp_hi: begin
            map_d.is_rom      = rom_area;
            map_d.is_saveram  = hi_sram;
            map_d.is_writable = hi_sram;
            map_d.mem_addr    = hi_sram
               ? cart_pkg::saveram_base + (off_6000 & cfg.saveram_mask)
               : {1'b0, a[22:0]} & cfg.rom_mask;
         end
         cart_pkg::lorom, cart_pkg::dsp_lo: begin
            map_d.is_rom      = rom_area;
            map_d.is_saveram  = lo_sram;
            map_d.is_writable = lo_sram;
            map_d.mem_addr    = lo_sram
               ? cart_pkg::saveram_base + ({9'd0, a[14:0]} & cfg.saveram_mask)
               : lo_rom_addr & cfg.rom_mask;
         end
         cart_pkg::exhirom: begin
            map_d.is_rom      = rom_area;
            map_d.is_saveram  = hi_sram;
            map_d.is_writable = hi_sram;
            map_d.mem_addr    = hi_sram
               ? cart_pkg::saveram_base + (off_6000 & cfg.saveram_mask)
               : {1'b0, !a[23], a[21:0]} & cfg.rom_mask;   // Upper 32 Mbit first
         end
         cart_pkg::bsx: begin
            map_d.is_rom      = rom_area;
            map_d.is_saveram  = bsx_sram;
            map_d.is_writable = bsx_writable;
            if (bsx_sram) begin
               map_d.mem_addr = cart_pkg::saveram_base + {9'd0, a[18:16], a[11:0]};
            end else if (bsx_writable) begin
               map_d.mem_addr = cart_pkg::bsx_psram_base + (a & 24'h0FFFFF);
            end else if (bsx_cart) begin
               map_d.mem_addr = cart_pkg::bsx_cart_base + (bsx_lo_addr & 24'h0FFFFF);
            end else begin
               map_d.mem_addr = bsx_rom_addr;
            end
         end
         cart_pkg::menu: begin
            map_d.is_rom      = rom_area;
            map_d.is_saveram  = hi_sram;
            map_d.is_writable = hi_sram;
            map_d.mem_addr    = hi_sram
               ? cart_pkg::menu_saveram_base + (off_6000 & cfg.saveram_mask)
               : ({1'b0, a[22:0]} & cfg.rom_mask) + cart_pkg::menu_rom_base;
         end
         default: ;   // Special stays unmapped
      endcase

      // DSP windows, LoROM board moves with ROM size
      if (cfg.mapper == cart_pkg::dsp_lo) begin
         map_d.dsp_hit = cfg.rom_mask[20]
            ? (a[22] & a[21] & !a[20] & !a[15])      // 60-6F:0000-7FFF
            : (!a[22] & a[21] & a[20] & a[15]);      // 30-3F:8000-FFFF
         map_d.dsp_a0  = a[14];
      end else if (cfg.mapper == cart_pkg::dsp_hi) begin
         map_d.dsp_hit = !a[22] & !a[21] & !a[20] & !a[15] & (&a[14:13]);  // 00-0F:6000
         map_d.dsp_a0  = a[12];
      end

      // Microcontroller phase overrides the address only
      if (mcu_phase) begin
         map_d.mem_addr = mcu_addr;
      end
   end

   ////////////////////////////////////////
   // Output register
   ////////////////////////////////////////

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         map <= '0;
      end else begin
         map <= map_d;
      end
   end

   // Bus phase passes the microcontroller address untouched
   mcu_addr_passthrough: assert property (
      @(posedge CLK) disable iff (!rst_n)
      mcu_phase |=> (map.mem_addr == $past(mcu_addr))
   );

endmodule

// ==== logic/cart_addr_top.sv ====
`timescale 1ns/1ps

module cart_addr_top #(
   parameter int FILTER_DEPTH = 4   // DSP select qualification
) (
   input  logic                 CLK,
   input  logic                 rst_n,
   input  cart_pkg::snes_req_t  req,
   input  logic [23:0]          mcu_addr,
   input  logic                 mcu_phase,
   input  logic                 cfg_write,
   input  cart_pkg::cfg_sel_t   cfg_sel,
   input  logic [23:0]          cfg_data,
   output cart_pkg::map_out_t   map,
   output logic                 dsp_enable,
   output logic                 use_bsx
);

   cart_pkg::map_cfg_t cfg;        // Mapper and masks
   logic [14:0]        bsx_regs;   // BS-X control bits

   ////////////////////////////////////////
   // State around the decoder
   ////////////////////////////////////////

   cart_config u_config (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .cfg_write (cfg_write),
      .cfg_sel   (cfg_sel),
      .cfg_data  (cfg_data),
      .cfg       (cfg),
      .use_bsx   (use_bsx)
   );

   bsx_reg_file u_bsx_regs (
      .CLK      (CLK),
      .rst_n    (rst_n),
      .req      (req),
      .mapper   (cfg.mapper),
      .bsx_regs (bsx_regs)
   );

   ////////////////////////////////////////
   // Decode and DSP qualification
   ////////////////////////////////////////

   cart_addr_map u_addr_map (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .req       (req),
      .mcu_addr  (mcu_addr),
      .mcu_phase (mcu_phase),
      .cfg       (cfg),
      .bsx_regs  (bsx_regs),
      .map       (map)
   );

   enable_filter #(
      .FILTER_DEPTH (FILTER_DEPTH)
   ) u_dsp_filter (
      .CLK    (CLK),
      .rst_n  (rst_n),
      .hit    (map.dsp_hit),   // Registered hit
      .enable (dsp_enable)
   );

endmodule

// ==== logic/cart_config.sv ====
`timescale 1ns/1ps

module cart_config (
   input  logic                CLK,
   input  logic                rst_n,
   input  logic                cfg_write,   // Strobe from microcontroller
   input  cart_pkg::cfg_sel_t  cfg_sel,
   input  logic [23:0]         cfg_data,
   output cart_pkg::map_cfg_t  cfg,
   output logic                use_bsx
);

   ////////////////////////////////////////
   // Config registers
   ////////////////////////////////////////

   // Menu mapper with full masks out of reset
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         cfg.mapper       <= cart_pkg::menu;
         cfg.rom_mask     <= '1;
         cfg.saveram_mask <= '1;
      end else if (cfg_write) begin
         case (cfg_sel)
            cart_pkg::cfg_mapper:
               cfg.mapper <= cart_pkg::mapper_t'(cfg_data[2:0]);  // Low bits only
            cart_pkg::cfg_rom_mask:
               cfg.rom_mask <= cfg_data;
            cart_pkg::cfg_saveram_mask:
               cfg.saveram_mask <= cfg_data;
            default: ;  // Spare select, no register
         endcase
      end
   end

   // Console side sees BS-X registers only in BS-X mode
   assign use_bsx = (cfg.mapper == cart_pkg::bsx);

   // Mapper field follows the low three data bits of its write
   mapper_from_low_bits: assert property (
      @(posedge CLK) disable iff (!rst_n)
      (cfg_write && cfg_sel == cart_pkg::cfg_mapper)
         |=> (cfg.mapper == $past(cfg_data[2:0]))
   );

endmodule

// ==== logic/cart_pkg.sv ====
package cart_pkg;

   ////////////////////////////////////////
   // Mapper codes and config selects
   ////////////////////////////////////////

   typedef enum logic [2:0] {
      hirom   = 3'd0,   // SRAM at 30-3F:6000-7FFF
      lorom   = 3'd1,   // SRAM at 70-7D
      exhirom = 3'd2,   // 48-64 Mbit, bank bit 23 inverted
      bsx     = 3'd3,   // Satellaview, register driven layout
      dsp_hi  = 3'd4,   // DSPx on HiROM board
      dsp_lo  = 3'd5,   // DSPx on LoROM board
      special = 3'd6,   // Interleaved 96 Mbit, not decoded
      menu    = 3'd7    // Menu ROM in upper memory
   } mapper_t;

   // Target of a microcontroller config write, code 3 is spare
   typedef enum logic [1:0] {
      cfg_mapper       = 2'd0,
      cfg_rom_mask     = 2'd1,
      cfg_saveram_mask = 2'd2
   } cfg_sel_t;

   ////////////////////////////////////////
   // Bundles
   ////////////////////////////////////////

   typedef struct packed {
      logic [23:0] addr;   // Console address, bank in 23:16
      logic        wr;     // Write strobe, one cycle
      logic [7:0]  data;   // Write data
   } snes_req_t;

   typedef struct packed {
      mapper_t     mapper;
      logic [23:0] rom_mask;
      logic [23:0] saveram_mask;
   } map_cfg_t;

   typedef struct packed {
      logic [23:0] mem_addr;     // Linear memory address
      logic        is_rom;
      logic        is_saveram;
      logic        is_writable;  // Save-RAM or BS-X PSRAM
      logic        msu_en;       // 2000-2007
      logic        srtc_en;      // 2800-2801
      logic        dsp_hit;      // Raw DSP window hit, unfiltered
      logic        dsp_a0;       // DSP data/status select
   } map_out_t;

   // Region bases in linear memory
   localparam logic [23:0] saveram_base      = 24'hE00000;
   localparam logic [23:0] bsx_psram_base    = 24'h400000;
   localparam logic [23:0] bsx_cart_base     = 24'h800000;
   localparam logic [23:0] menu_rom_base     = 24'hE00000;
   localparam logic [23:0] menu_saveram_base = 24'hFF0000;

endpackage

// ==== logic/enable_filter.sv ====
`timescale 1ns/1ps

module enable_filter #(
   parameter int FILTER_DEPTH = 4   // Samples required
) (
   input  logic CLK,
   input  logic rst_n,
   input  logic hit,      // Raw select
   output logic enable    // Qualified select
);

   logic [FILTER_DEPTH-1:0] samples_q;   // Newest sample in bit 0

   ////////////////////////////////////////
   // Sample history
   ////////////////////////////////////////

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         samples_q <= '0;
      end else begin
         samples_q[0] <= hit;
         for (int i = 1; i < FILTER_DEPTH; i++) begin
            samples_q[i] <= samples_q[i-1];   // Age by one sample
         end
      end
   end

   // High only after a full run of hits
   assign enable = &samples_q;

   // A low hit clears the select on the next edge
   drop_after_low_hit: assert property (
      @(posedge CLK) disable iff (!rst_n)
      !hit |=> !enable
   );

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile and run the cart address decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f all.f --top-module tb_cart_addr -o tb_cart_addr
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build returned status $status"
   exit 1
fi

./obj_dir/tb_cart_addr > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation returned status $status"
   exit 1
fi

# Result comes from the log
if grep -q "Regression failed" "$LOG"; then
   exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
   echo "no result line in $LOG"
   exit 1
fi
exit 0
